// ==== Makefile ====
# override any of these on the command line, e.g. make sim LOG=run.log
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_decode
RTL_TOP   ?= decode_stage_top
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== filelist.f ====
hw/rv_isa_pkg.sv
hw/decode_pkg.sv
hw/fetch_unpack.sv
hw/lane_decoder.sv
hw/decode_register.sv
hw/decode_stage_top.sv
sim/tb_decode.sv

// ==== hw/decode_pkg.sv ====
package decode_pkg;

  import rv_isa_pkg::*;

  typedef struct packed {
    logic  ready;
    xlen_t pc;
    xlen_t instr;
  } fetch_slot_t;

  typedef struct packed {
    logic wren;
    logic rden1;
    logic rden2;
    logic cwren;
    logic crden;
    logic alunit;
    logic auipc;
    logic lui;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic nop;
    logic csreg;
    logic fence;
    logic ecall;
    logic ebreak;
    logic mret;
    logic wfi;
    logic valid;
    logic exception;
  } dec_ops_t;

  typedef struct packed {
    xlen_t       pc;
    xlen_t       npc;
    xlen_t       instr;
    logic [4:0]  waddr;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [11:0] caddr;
    xlen_t       imm;
    dec_ops_t    op;
    alu_op_t     alu_op;
    bcu_op_t     bcu_op;
    lsu_op_t     lsu_op;
    csr_op_t     csr_op;
  } lane_t;

  // execute fence, trap, mret, predictor miss, writeback flush
  typedef struct packed {
    logic fence;
    logic trap;
    logic mret;
    logic pred_miss;
    logic wb_clear;
  } flush_t;

  // a slot with no instruction
  localparam fetch_slot_t bubble_slot = '{ready: 1'b0, pc: '1, instr: '0};

  localparam lane_t init_lane = '{pc: '1, default: '0};

endpackage

// ==== hw/decode_register.sv ====
`timescale 1ns/10ps

module decode_register #(
  parameter int LANES = 2
) (
  input  logic                          clock,
  input  logic                          reset,
  input  decode_pkg::lane_t [LANES-1:0] lanes,
  input  decode_pkg::flush_t            flush,
  output decode_pkg::lane_t [LANES-1:0] y,
  output decode_pkg::lane_t [LANES-1:0] q
);

  import decode_pkg::*;

  logic              clear;
  lane_t [LANES-1:0] r;
  logic  [LANES-1:0] q_valid;

  assign clear = flush.fence | flush.trap | flush.mret | flush.pred_miss | flush.wb_clear;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      y[i] = clear ? init_lane : lanes[i];  // kill in the same cycle
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < LANES; i++) begin
        r[i] <= init_lane;
      end
    end else begin
      r <= y;
    end
  end

  assign q = r;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      q_valid[i] = q[i].op.valid;
    end
  end

  // a clear must still hide every lane one edge later
  clear_kills_q: assert property (@(posedge clock) disable iff (!reset)
    clear |=> (q_valid == '0));

  reset_empties_q: assert property (@(posedge clock)
    !reset |=> (q_valid == '0));

endmodule

// ==== hw/decode_stage_top.sv ====
`timescale 1ns/10ps

module decode_stage_top #(
  parameter int LANES = 2
) (
  input  logic                                clock,
  input  logic                                reset,
  input  decode_pkg::fetch_slot_t [LANES-1:0] fetch,
  input  decode_pkg::flush_t                  flush,
  output decode_pkg::lane_t       [LANES-1:0] y,
  output decode_pkg::lane_t       [LANES-1:0] q
);

  import decode_pkg::*;
  import rv_isa_pkg::*;

  fetch_slot_t [LANES-1:0] slots;
  xlen_t       [LANES-1:0] npc;
  lane_t       [LANES-1:0] lanes;

  fetch_unpack #(
    .LANES(LANES)
  ) u_unpack (
    .fetch(fetch),
    .slots(slots),
    .npc  (npc)
  );

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    lane_decoder u_dec (
      .slot(slots[i]),
      .npc (npc[i]),
      .lane(lanes[i])
    );
  end

  decode_register #(
    .LANES(LANES)
  ) u_reg (
    .clock(clock),
    .reset(reset),
    .lanes(lanes),
    .flush(flush),
    .y    (y),
    .q    (q)
  );

endmodule

// ==== hw/fetch_unpack.sv ====
`timescale 1ns/10ps

module fetch_unpack #(
  parameter int LANES = 2
) (
  input  decode_pkg::fetch_slot_t [LANES-1:0] fetch,
  output decode_pkg::fetch_slot_t [LANES-1:0] slots,
  output rv_isa_pkg::xlen_t       [LANES-1:0] npc
);

  import decode_pkg::*;
  import rv_isa_pkg::*;

  xlen_t [LANES-1:0] ilen;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      slots[i] = fetch[i].ready ? fetch[i] : bubble_slot;
    end
  end

  // instruction length from the two low bits, 11 means a full word
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      ilen[i] = (&slots[i].instr[1:0]) ? 32'd4 : 32'd2;
      npc[i] = slots[i].pc + ilen[i];  // wraps for a bubble
    end
  end

endmodule

// ==== hw/lane_decoder.sv ====
`timescale 1ns/10ps

module lane_decoder (
  input  decode_pkg::fetch_slot_t slot,
  input  rv_isa_pkg::xlen_t       npc,
  output decode_pkg::lane_t       lane
);

  import rv_isa_pkg::*;
  import decode_pkg::*;

  instr_word_u iw;
  dec_ops_t    ops;
  dec_ops_t    ops_out;
  xlen_t       imm;
  xlen_t       imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_t     alu_op;
  bcu_op_t     bcu_op;
  lsu_op_t     lsu_op;
  csr_op_t     csr_op;
  logic        known;

  function automatic alu_op_t alu_sel(logic [2:0] funct3, logic alt);
    case (funct3)
      3'b000:  alu_sel = alt ? alu_sub : alu_add;
      3'b001:  alu_sel = alu_sll;
      3'b010:  alu_sel = alu_slt;
      3'b011:  alu_sel = alu_sltu;
      3'b100:  alu_sel = alu_xor;
      3'b101:  alu_sel = alt ? alu_sra : alu_srl;
      3'b110:  alu_sel = alu_or;
      default: alu_sel = alu_and;
    endcase
  endfunction

  assign iw = slot.instr;

  assign imm_i = {{20{iw.i.imm12[11]}}, iw.i.imm12};
  assign imm_s = {{20{iw.r.funct7[6]}}, iw.r.funct7, iw.r.rd};
  assign imm_b = {{20{iw.r.funct7[6]}}, iw.r.rd[0], iw.r.funct7[5:0], iw.r.rd[4:1], 1'b0};
  assign imm_u = {iw.i.imm12, iw.i.rs1, iw.i.funct3, 12'b0};
  assign imm_j = {{12{iw.i.imm12[11]}}, iw.i.rs1, iw.i.funct3, iw.i.imm12[0],
                  iw.i.imm12[10:1], 1'b0};

  always_comb begin
    ops = '0;
    imm = '0;
    alu_op = alu_add;
    bcu_op = bcu_beq;
    lsu_op = lsu_lb;
    csr_op = csr_none;
    known = 1'b1;
    case (iw.r.opcode)
      opc_lui: begin
        ops.lui = 1'b1;
        ops.wren = 1'b1;
        imm = imm_u;
      end
      opc_auipc: begin
        ops.auipc = 1'b1;
        ops.wren = 1'b1;
        imm = imm_u;
      end
      opc_jal: begin
        ops.jal = 1'b1;
        ops.wren = 1'b1;
        imm = imm_j;
      end
      opc_jalr: begin
        known = (iw.r.funct3 == 3'b000);
        ops.jalr = 1'b1;
        ops.wren = 1'b1;
        ops.rden1 = 1'b1;
        imm = imm_i;
      end
      opc_branch: begin
        ops.branch = 1'b1;
        ops.rden1 = 1'b1;
        ops.rden2 = 1'b1;
        imm = imm_b;
        case (iw.r.funct3)
          3'b000:  bcu_op = bcu_beq;
          3'b001:  bcu_op = bcu_bne;
          3'b100:  bcu_op = bcu_blt;
          3'b101:  bcu_op = bcu_bge;
          3'b110:  bcu_op = bcu_bltu;
          3'b111:  bcu_op = bcu_bgeu;
          default: known = 1'b0;
        endcase
      end
      opc_load: begin
        ops.load = 1'b1;
        ops.wren = 1'b1;
        ops.rden1 = 1'b1;
        imm = imm_i;
        case (iw.r.funct3)
          3'b000:  lsu_op = lsu_lb;
          3'b001:  lsu_op = lsu_lh;
          3'b010:  lsu_op = lsu_lw;
          3'b100:  lsu_op = lsu_lbu;
          3'b101:  lsu_op = lsu_lhu;
          default: known = 1'b0;
        endcase
      end
      opc_store: begin
        ops.store = 1'b1;
        ops.rden1 = 1'b1;
        ops.rden2 = 1'b1;
        imm = imm_s;
        case (iw.r.funct3)
          3'b000:  lsu_op = lsu_sb;
          3'b001:  lsu_op = lsu_sh;
          3'b010:  lsu_op = lsu_sw;
          default: known = 1'b0;
        endcase
      end
      opc_op_imm: begin
        ops.alunit = 1'b1;
        ops.wren = 1'b1;
        ops.rden1 = 1'b1;
        ops.nop = (iw.r.rd == 5'd0);  // hint, result dropped
        imm = imm_i;
        alu_op = alu_sel(iw.r.funct3, (iw.r.funct3 == 3'b101) && iw.r.funct7[5]);
        if (iw.r.funct3 == 3'b001) begin
          known = (iw.r.funct7 == 7'd0);
        end else if (iw.r.funct3 == 3'b101) begin
          known = (iw.r.funct7 == 7'd0) || (iw.r.funct7 == funct7_alt);
        end
      end
      opc_op: begin
        ops.alunit = 1'b1;
        ops.wren = 1'b1;
        ops.rden1 = 1'b1;
        ops.rden2 = 1'b1;
        alu_op = alu_sel(iw.r.funct3, iw.r.funct7[5]);
        known = (iw.r.funct7 == 7'd0) ||
                (iw.r.funct7 == funct7_alt &&
                 (iw.r.funct3 == 3'b000 || iw.r.funct3 == 3'b101));  // only sub and sra
      end
      opc_misc_mem: begin
        ops.fence = 1'b1;  // fence and fence.i
        known = (iw.r.funct3[2:1] == 2'b00);
      end
      opc_system: begin
        if (iw.r.funct3 == 3'b000) begin
          case (slot.instr)
            instr_ecall:  ops.ecall = 1'b1;
            instr_ebreak: ops.ebreak = 1'b1;
            instr_mret:   ops.mret = 1'b1;
            instr_wfi:    ops.wfi = 1'b1;
            default:      known = 1'b0;
          endcase
        end else begin
          ops.csreg = 1'b1;
          ops.wren = 1'b1;
          ops.rden1 = ~iw.r.funct3[2];
          ops.crden = (iw.r.funct3[1:0] != 2'b01) || (iw.r.rd != 5'd0);
          ops.cwren = (iw.r.funct3[1:0] == 2'b01) || (iw.r.rs1 != 5'd0);
          imm = {27'd0, iw.r.rs1};  // uimm for the immediate forms
          csr_op = csr_op_t'(iw.r.funct3[1:0]);
          known = (iw.r.funct3 != 3'b100);
        end
      end
      default: known = 1'b0;
    endcase
  end

  // a ready word that does not decode still travels as a trap
  always_comb begin
    ops_out = known ? ops : '0;
    ops_out.valid = slot.ready;
    ops_out.exception = slot.ready & ~known;
  end

  always_comb begin
    lane.pc = slot.pc;
    lane.npc = npc;
    lane.instr = slot.instr;
    lane.waddr = iw.r.rd;
    lane.raddr1 = iw.r.rs1;
    lane.raddr2 = iw.r.rs2;
    lane.caddr = iw.i.imm12;
    lane.imm = known ? imm : '0;
    lane.op = ops_out;
    lane.alu_op = known ? alu_op : alu_add;
    lane.bcu_op = known ? bcu_op : bcu_beq;
    lane.lsu_op = known ? lsu_op : lsu_lb;
    lane.csr_op = known ? csr_op : csr_none;
  end

endmodule

// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

  typedef logic [31:0] xlen_t;

  // major opcodes of the base integer set
  typedef enum logic [6:0] {
    opc_load     = 7'b0000011,
    opc_misc_mem = 7'b0001111,
    opc_op_imm   = 7'b0010011,
    opc_auipc    = 7'b0010111,
    opc_store    = 7'b0100011,
    opc_op       = 7'b0110011,
    opc_lui      = 7'b0110111,
    opc_branch   = 7'b1100011,
    opc_jalr     = 7'b1100111,
    opc_jal      = 7'b1101111,
    opc_system   = 7'b1110011
  } opcode_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;  // also the csr address
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_word_u;

  localparam logic [6:0] funct7_alt = 7'b0100000;  // sub, sra, srai

  // system words decoded as a whole
  localparam xlen_t instr_ecall  = 32'h00000073;
  localparam xlen_t instr_ebreak = 32'h00100073;
  localparam xlen_t instr_mret   = 32'h30200073;
  localparam xlen_t instr_wfi    = 32'h10500073;

  typedef logic [3:0] alu_op_t;
  localparam alu_op_t alu_add  = 4'd0;
  localparam alu_op_t alu_sub  = 4'd1;
  localparam alu_op_t alu_sll  = 4'd2;
  localparam alu_op_t alu_slt  = 4'd3;
  localparam alu_op_t alu_sltu = 4'd4;
  localparam alu_op_t alu_xor  = 4'd5;
  localparam alu_op_t alu_srl  = 4'd6;
  localparam alu_op_t alu_sra  = 4'd7;
  localparam alu_op_t alu_or   = 4'd8;
  localparam alu_op_t alu_and  = 4'd9;

  typedef logic [2:0] bcu_op_t;
  localparam bcu_op_t bcu_beq  = 3'd0;
  localparam bcu_op_t bcu_bne  = 3'd1;
  localparam bcu_op_t bcu_blt  = 3'd2;
  localparam bcu_op_t bcu_bge  = 3'd3;
  localparam bcu_op_t bcu_bltu = 3'd4;
  localparam bcu_op_t bcu_bgeu = 3'd5;

  typedef logic [2:0] lsu_op_t;
  localparam lsu_op_t lsu_lb  = 3'd0;
  localparam lsu_op_t lsu_lh  = 3'd1;
  localparam lsu_op_t lsu_lw  = 3'd2;
  localparam lsu_op_t lsu_lbu = 3'd3;
  localparam lsu_op_t lsu_lhu = 3'd4;
  localparam lsu_op_t lsu_sb  = 3'd5;
  localparam lsu_op_t lsu_sh  = 3'd6;
  localparam lsu_op_t lsu_sw  = 3'd7;

  typedef logic [1:0] csr_op_t;
  localparam csr_op_t csr_none = 2'd0;
  localparam csr_op_t csr_rw   = 2'd1;
  localparam csr_op_t csr_rs   = 2'd2;
  localparam csr_op_t csr_rc   = 2'd3;

endpackage

// ==== sim/decode_tests.txt ====
# name flush | per lane: ready pc instr waddr raddr1 raddr2 imm flags
# flags is the dec_ops_t word, wren at bit 21 down to valid bit 1, exception bit 0
r_add_sub 0 1 100 002081B3 3 1 2 0 390002 1 104 403100B3 1 2 3 0 390002
i_addi_srai 0 1 108 FFF30293 5 6 1F FFFFFFFF 310002 1 10C 4032D293 5 5 3 403 310002
s_store 0 1 110 00712423 8 2 7 8 180202 1 114 FE712E23 1C 2 7 FFFFFFFC 180202
b_beq_u_lui 0 1 118 FE208CE3 19 1 2 FFFFFFF8 180802 1 11C 12345537 A 8 3 12345000 204002
u_auipc_j_jal 0 1 120 FFFFF097 1 1F 1F FFFFF000 208002 1 124 001000EF 1 0 1 800 202002
j_back_jalr 0 1 128 FFDFF06F 0 1F 1D FFFFFFFC 202002 1 12C 00C280E7 1 5 C C 301002
i_load_csr 0 1 130 FF04A203 4 9 10 FFFFFFF0 300402 1 134 30019173 2 3 0 3 360082
sys_ecall_mret 0 1 138 00000073 0 0 0 0 22 1 13C 30200073 0 0 2 0 A
fence_badop 0 1 140 0FF0000F 0 0 1F 0 42 1 144 0000007F 0 0 0 0 3
bad_words 0 1 148 FFFFFFFF 1F 1F 1F 0 3 1 14C 022081B3 3 1 2 0 3
short_word 0 1 150 00004501 A 0 0 0 3 1 152 002081B3 3 1 2 0 390002
bubble_both 0 0 200 002081B3 0 0 0 0 0 0 204 FFF30293 0 0 0 0 0
bubble_low 0 0 208 002081B3 0 0 0 0 0 1 20C 00712423 8 2 7 8 180202
bubble_high 0 1 210 403100B3 1 2 3 0 390002 0 214 00004501 0 0 0 0 0
pc_wrap 0 1 FFFFFFFC 002081B3 3 1 2 0 390002 1 FFFFFFFE 00004501 A 0 0 0 3
flush_fence 10 1 300 002081B3 3 1 2 0 390002 1 304 403100B3 1 2 3 0 390002
flush_trap 8 1 308 FFF30293 5 6 1F FFFFFFFF 310002 1 30C 0000007F 0 0 0 0 3
flush_mret 4 1 310 00712423 8 2 7 8 180202 1 314 30200073 0 0 2 0 A
flush_miss 2 1 318 FE208CE3 19 1 2 FFFFFFF8 180802 1 31C 001000EF 1 0 1 800 202002
flush_wb 1 1 320 12345537 A 8 3 12345000 204002 0 324 002081B3 0 0 0 0 0
after_flush 0 1 328 30019173 2 3 0 3 360082 1 32C FF04A203 4 9 10 FFFFFFF0 300402

// ==== sim/tb_decode.sv ====
`timescale 1ns/10ps

module tb_decode;

  import rv_isa_pkg::*;
  import decode_pkg::*;

  localparam int LANES = 2;
  localparam int MAXV = 64;
  localparam int MAX_GAP = 3;
  localparam string TEST_FILE = "sim/decode_tests.txt";

  logic clock;
  logic reset;
  fetch_slot_t [LANES-1:0] fetch;
  flush_t flush;
  lane_t [LANES-1:0] y;
  lane_t [LANES-1:0] q;

  // vector storage
  string       v_name [MAXV];
  logic [4:0]  v_flush [MAXV];
  logic        v_ready [MAXV][LANES];
  logic [31:0] v_pc [MAXV][LANES];
  logic [31:0] v_instr [MAXV][LANES];
  logic [4:0]  v_wa [MAXV][LANES];
  logic [4:0]  v_ra1 [MAXV][LANES];
  logic [4:0]  v_ra2 [MAXV][LANES];
  logic [31:0] v_imm [MAXV][LANES];
  logic [21:0] v_flags [MAXV][LANES];

  int n_vec = 0;
  int errors = 0;
  int limit_cycles = 0;
  lane_t empty_lane;

  decode_stage_top #(
    .LANES(LANES)
  ) DUT (
    .clock(clock),
    .reset(reset),
    .fetch(fetch),
    .flush(flush),
    .y    (y),
    .q    (q)
  );

  always #50 clock = ~clock;

  task automatic compare(input string sig, input logic [255:0] got, input logic [255:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %0h expected %0h", sig, got, exp);
      errors++;
    end
  endtask

  task automatic load_tests();
    int fd;
    int n;
    string line;
    string nm;
    logic [31:0] f[18];
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("could not open the test vector file %s", TEST_FILE);
      errors++;
      return;
    end
    while (!$feof(fd) && n_vec < MAXV) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", nm,
                  f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                  f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
      if (n != 18) begin
        $display("a line of the test file has %0d fields instead of 18", n);
        errors++;
        continue;
      end
      v_name[n_vec] = nm;
      v_flush[n_vec] = f[1][4:0];
      for (int l = 0; l < LANES; l++) begin
        v_ready[n_vec][l] = f[2+8*l][0];
        v_pc[n_vec][l] = f[3+8*l];
        v_instr[n_vec][l] = f[4+8*l];
        v_wa[n_vec][l] = f[5+8*l][4:0];
        v_ra1[n_vec][l] = f[6+8*l][4:0];
        v_ra2[n_vec][l] = f[7+8*l][4:0];
        v_imm[n_vec][l] = f[8+8*l];
        v_flags[n_vec][l] = f[9+8*l][21:0];
      end
      n_vec++;
    end
    $fclose(fd);
  endtask

  task automatic drive_idle();
    flush = '0;
    for (int l = 0; l < LANES; l++) begin
      fetch[l] = '{ready: 1'b0, pc: 32'h0, instr: 32'h0};
    end
  endtask

  task automatic drive_vector(input int v);
    flush = v_flush[v];
    for (int l = 0; l < LANES; l++) begin
      fetch[l] = '{ready: v_ready[v][l], pc: v_pc[v][l], instr: v_instr[v][l]};
    end
  endtask

  // unit sub-ops the ISA gives a decoded word, as {alu, bcu, lsu, csr}
  function automatic logic [11:0] expected_subops(input logic [31:0] w);
    alu_op_t alu_by_f3 [8];
    alu_op_t alu;
    bcu_op_t bcu;
    lsu_op_t lsu;
    csr_op_t csr;
    alu_by_f3 = '{alu_add, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_or, alu_and};
    alu = alu_add;
    bcu = bcu_beq;
    lsu = lsu_lb;
    csr = csr_none;
    case (w[6:0])
      opc_op, opc_op_imm: begin
        alu = alu_by_f3[w[14:12]];
        if (w[14:12] == 3'b101 && w[30]) begin
          alu = alu_sra;
        end else if (w[14:12] == 3'b000 && w[30] && w[6:0] == opc_op) begin
          alu = alu_sub;  // no subi
        end
      end
      opc_branch: begin
        case (w[14:12])
          3'b001:  bcu = bcu_bne;
          3'b100:  bcu = bcu_blt;
          3'b101:  bcu = bcu_bge;
          3'b110:  bcu = bcu_bltu;
          3'b111:  bcu = bcu_bgeu;
          default: bcu = bcu_beq;
        endcase
      end
      opc_load: begin
        case (w[14:12])
          3'b001:  lsu = lsu_lh;
          3'b010:  lsu = lsu_lw;
          3'b100:  lsu = lsu_lbu;
          3'b101:  lsu = lsu_lhu;
          default: lsu = lsu_lb;
        endcase
      end
      opc_store: begin
        case (w[14:12])
          3'b001:  lsu = lsu_sh;
          3'b010:  lsu = lsu_sw;
          default: lsu = lsu_sb;
        endcase
      end
      opc_system: begin
        case (w[13:12])
          2'b01:   csr = csr_rw;
          2'b10:   csr = csr_rs;
          2'b11:   csr = csr_rc;
          default: csr = csr_none;
        endcase
      end
      default: ;
    endcase
    return {alu, bcu, lsu, csr};
  endfunction

  // expected fields follow the bubble, length and kill rules
  task automatic check_lane(input string where, input lane_t got, input int v, input int l);
    logic [31:0] pc;
    logic [31:0] word;
    logic [31:0] npc;
    logic [11:0] subops;
    pc = v_ready[v][l] ? v_pc[v][l] : 32'hffff_ffff;
    word = v_ready[v][l] ? v_instr[v][l] : 32'h0;
    npc = pc + ((word[1:0] == 2'b11) ? 32'd4 : 32'd2);
    subops = (v_ready[v][l] && !v_flags[v][l][0]) ? expected_subops(word) : 12'h0;
    if (v_flush[v] != 0) begin
      compare({where, " killed lane"}, got, empty_lane);
      return;
    end
    compare({where, ".pc"}, got.pc, pc);
    compare({where, ".npc"}, got.npc, npc);
    compare({where, ".instr"}, got.instr, word);
    compare({where, ".waddr"}, got.waddr, v_wa[v][l]);
    compare({where, ".raddr1"}, got.raddr1, v_ra1[v][l]);
    compare({where, ".raddr2"}, got.raddr2, v_ra2[v][l]);
    compare({where, ".caddr"}, got.caddr, word[31:20]);
    compare({where, ".imm"}, got.imm, v_imm[v][l]);
    compare({where, ".subops"}, {got.alu_op, got.bcu_op, got.lsu_op, got.csr_op}, subops);
    compare({where, ".valid"}, got.op.valid, v_flags[v][l][1]);
    compare({where, ".exception"}, got.op.exception, v_flags[v][l][0]);
    compare({where, ".op"}, got.op, v_flags[v][l]);
  endtask

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clock);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int gap;
    int err_before;
    int pass_tests;
    int fail_tests;
    pass_tests = 0;
    fail_tests = 0;
    void'($urandom(32'hb545));
    empty_lane = '0;
    empty_lane.pc = 32'hffff_ffff;
    clock = 1'b0;
    reset = 1'b0;
    drive_idle();
    load_tests();
    limit_cycles = 16 + 4 + n_vec * (MAX_GAP + 2) + 20;
    repeat (16) @(posedge clock);
    #1 reset = 1'b1;
    err_before = errors;
    for (int l = 0; l < LANES; l++) begin
      compare($sformatf("q[%0d] after reset", l), q[l], empty_lane);
    end
    $display("test reset: %s", (errors == err_before) ? "ok" : "failed");
    if (errors == err_before) pass_tests++;
    else fail_tests++;
    for (int v = 0; v < n_vec; v++) begin
      err_before = errors;
      drive_vector(v);
      @(negedge clock);
      for (int l = 0; l < LANES; l++) begin
        check_lane($sformatf("y[%0d]", l), y[l], v, l);
      end
      @(posedge clock);
      #1;
      for (int l = 0; l < LANES; l++) begin
        check_lane($sformatf("q[%0d]", l), q[l], v, l);
      end
      drive_idle();
      gap = $urandom % (MAX_GAP + 1);  // idle cycles between vectors
      repeat (gap) @(posedge clock);
      if (gap > 0) #1;
      $display("test %s: %s", v_name[v], (errors == err_before) ? "ok" : "failed");
      if (errors == err_before) pass_tests++;
      else fail_tests++;
    end
    $display("tests passed %0d, failed %0d, mismatches %0d", pass_tests, fail_tests, errors);
    if (fail_tests == 0 && errors == 0 && n_vec > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
